/* logic/rv_core_pkg.sv */
package rv_core_pkg;

	// Major opcodes, instruction bits [6:0]
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_ITYPE  = 7'b0010011,
		OP_RTYPE  = 7'b0110011,
		OP_FENCE  = 7'b0001111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	// Operand A select
	// RS1 is the rs1 field zero-extended, for immediate CSR forms
	typedef enum logic [1:0] {
		SRC_A_NONE = 2'd0,
		SRC_A_PC   = 2'd1,
		SRC_A_RD1  = 2'd2,
		SRC_A_RS1  = 2'd3
	} alu_src_a_e;

	// Operand B select
	typedef enum logic [1:0] {
		SRC_B_NONE = 2'd0,
		SRC_B_IMM  = 2'd1,
		SRC_B_RD2  = 2'd2,
		SRC_B_CSR  = 2'd3
	} alu_src_b_e;

	// Register file write-data source
	typedef enum logic [2:0] {
		RF_WD_NONE = 3'd0,
		RF_WD_LUI  = 3'd1,
		RF_WD_ALU  = 3'd2,
		RF_WD_JUMP = 3'd3,
		RF_WD_LOAD = 3'd4,
		RF_WD_CSR  = 3'd5
	} rf_wd_e;

	// Zicsr funct3 encodings
	typedef enum logic [2:0] {
		CSR_NONE = 3'b000,
		CSR_RW   = 3'b001,
		CSR_RS   = 3'b010,
		CSR_RC   = 3'b011,
		CSR_RWI  = 3'b101,
		CSR_RSI  = 3'b110,
		CSR_RCI  = 3'b111
	} csr_op_e;

	// ALU operation class
	typedef enum logic [1:0] {
		ALU_ADD   = 2'd0,
		ALU_FUNCT = 2'd1,
		ALU_CMP   = 2'd2,
		ALU_CSR   = 2'd3
	} alu_op_e;

	// Two-cycle instruction phase
	typedef enum logic {
		PH_FETCH   = 1'b0,
		PH_EXECUTE = 1'b1
	} phase_e;

	// Control word from the control unit
	typedef struct packed {
		logic       jump;
		logic       branch;
		alu_src_a_e alu_src_a;
		alu_src_b_e alu_src_b;
		alu_op_e    alu_op;
		csr_op_e    csr_op;
		logic       rf_write;
		rf_wd_e     rf_wd_select;
		logic       mem_read;
		logic       mem_write;
	} ctrl_t;

	// Instruction fields after decode
	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  funct3;
		logic        funct7_5;
		logic [11:0] csr_addr;
		logic [31:0] imm;
	} decoded_t;

endpackage

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic [31:0]           instr,
	output rv_core_pkg::decoded_t dec
);
	import rv_core_pkg::*;

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	// Immediate formats, all sign-extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	// Branch offset, bit 0 always zero
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	// Upper immediate already shifted into place
	assign imm_u = {instr[31:12], 12'b0};
	// Jump offset, bit 0 always zero
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// Fixed field positions
		dec.opcode   = opcode_e'(instr[6:0]);
		dec.rd       = instr[11:7];
		dec.rs1      = instr[19:15];
		dec.rs2      = instr[24:20];
		dec.funct3   = instr[14:12];
		// SUB and SRA select
		dec.funct7_5 = instr[30];
		dec.csr_addr = instr[31:20];

		// Immediate chosen by format
		case (dec.opcode)
			OP_LUI, OP_AUIPC: begin
				dec.imm = imm_u;
			end
			OP_JAL: begin
				dec.imm = imm_j;
			end
			OP_BRANCH: begin
				dec.imm = imm_b;
			end
			OP_STORE: begin
				dec.imm = imm_s;
			end
			default: begin
				// JALR, loads, I-type, system
				dec.imm = imm_i;
			end
		endcase
	end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
	input  logic                 write_done,
	input  rv_core_pkg::opcode_e opcode,
	input  logic [2:0]           funct3,
	output rv_core_pkg::ctrl_t   ctrl
);
	import rv_core_pkg::*;

	always_comb begin
		// Everything idle unless the opcode asks for it
		ctrl.jump         = 1'b0;
		ctrl.branch       = 1'b0;
		ctrl.alu_src_a    = SRC_A_NONE;
		ctrl.alu_src_b    = SRC_B_NONE;
		ctrl.alu_op       = ALU_ADD;
		ctrl.csr_op       = CSR_NONE;
		ctrl.rf_write     = 1'b0;
		ctrl.rf_wd_select = RF_WD_NONE;
		ctrl.mem_read     = 1'b0;
		ctrl.mem_write    = 1'b0;

		// Only drive control in the execute cycle
		if (write_done) begin
			case (opcode)
				OP_LUI: begin
					// Immediate goes straight to rd
					ctrl.rf_write     = 1'b1;
					ctrl.rf_wd_select = RF_WD_LUI;
				end
				OP_AUIPC: begin
					// PC + upper immediate
					ctrl.alu_src_a    = SRC_A_PC;
					ctrl.alu_src_b    = SRC_B_IMM;
					ctrl.rf_write     = 1'b1;
					ctrl.rf_wd_select = RF_WD_ALU;
				end
				OP_JAL: begin
					// Target PC + imm, link PC+4
					ctrl.jump         = 1'b1;
					ctrl.alu_src_a    = SRC_A_PC;
					ctrl.alu_src_b    = SRC_B_IMM;
					ctrl.rf_write     = 1'b1;
					ctrl.rf_wd_select = RF_WD_JUMP;
				end
				OP_JALR: begin
					// Target R[rs1] + imm
					ctrl.jump         = 1'b1;
					ctrl.alu_src_a    = SRC_A_RD1;
					ctrl.alu_src_b    = SRC_B_IMM;
					ctrl.rf_write     = 1'b1;
					ctrl.rf_wd_select = RF_WD_JUMP;
				end
				OP_BRANCH: begin
					// Compare R[rs1] with R[rs2]
					ctrl.branch    = 1'b1;
					ctrl.alu_src_a = SRC_A_RD1;
					ctrl.alu_src_b = SRC_B_RD2;
					ctrl.alu_op    = ALU_CMP;
				end
				OP_LOAD: begin
					// Address R[rs1] + imm
					ctrl.alu_src_a    = SRC_A_RD1;
					ctrl.alu_src_b    = SRC_B_IMM;
					ctrl.rf_write     = 1'b1;
					ctrl.rf_wd_select = RF_WD_LOAD;
					ctrl.mem_read     = 1'b1;
				end
				OP_STORE: begin
					ctrl.alu_src_a = SRC_A_RD1;
					ctrl.alu_src_b = SRC_B_IMM;
					ctrl.mem_write = 1'b1;
				end
				OP_ITYPE: begin
					// Arithmetic on R[rs1] and imm
					ctrl.alu_src_a    = SRC_A_RD1;
					ctrl.alu_src_b    = SRC_B_IMM;
					ctrl.alu_op       = ALU_FUNCT;
					ctrl.rf_write     = 1'b1;
					ctrl.rf_wd_select = RF_WD_ALU;
				end
				OP_RTYPE: begin
					// Arithmetic on R[rs1] and R[rs2]
					ctrl.alu_src_a    = SRC_A_RD1;
					ctrl.alu_src_b    = SRC_B_RD2;
					ctrl.alu_op       = ALU_FUNCT;
					ctrl.rf_write     = 1'b1;
					ctrl.rf_wd_select = RF_WD_ALU;
				end
				OP_SYSTEM: begin
					// funct3 of 0 or 4 is ECALL/EBREAK or reserved, nothing done
					if (funct3[1:0] != 2'b00) begin
						ctrl.csr_op       = csr_op_e'(funct3);
						ctrl.alu_op       = ALU_CSR;
						// Old CSR value as B
						ctrl.alu_src_b    = SRC_B_CSR;
						// Register forms use R[rs1], immediate forms the rs1 field
						ctrl.alu_src_a    = funct3[2] ? SRC_A_RS1 : SRC_A_RD1;
						ctrl.rf_write     = 1'b1;
						ctrl.rf_wd_select = RF_WD_CSR;
					end
				end
				default: begin
					// FENCE and unknown opcodes stay idle
				end
			endcase
		end
	end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic [31:0] wdata,
	input  logic        we,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	// x1..x31 only, x0 has no storage
	logic [31:0] regs [1:31];

	// Combinational reads, x0 reads as zero
	assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (we && rd != 5'd0) begin
			// Writes to x0 dropped
			regs[rd] <= wdata;
		end
	end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
	input  rv_core_pkg::ctrl_t    ctrl,
	input  rv_core_pkg::decoded_t dec,
	input  logic [31:0]           pc,
	input  logic [31:0]           rd1,
	input  logic [31:0]           rd2,
	input  logic [31:0]           csr_rdata,
	output logic [31:0]           result,
	output logic                  branch_taken
);
	import rv_core_pkg::*;

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] sra_result;
	logic [31:0] funct_result;
	logic [31:0] csr_new;
	logic        cmp_true;

	always_comb begin
		// Operand A
		case (ctrl.alu_src_a)
			SRC_A_PC:  op_a = pc;
			SRC_A_RD1: op_a = rd1;
			SRC_A_RS1: op_a = {27'd0, dec.rs1};
			default:   op_a = 32'd0;
		endcase
		// Operand B
		case (ctrl.alu_src_b)
			SRC_B_IMM: op_b = dec.imm;
			SRC_B_RD2: op_b = rd2;
			SRC_B_CSR: op_b = csr_rdata;
			default:   op_b = 32'd0;
		endcase
	end

	// Kept apart so the shift stays signed
	assign sra_result = $signed(op_a) >>> op_b[4:0];

	always_comb begin
		// R and I arithmetic by funct3
		case (dec.funct3)
			3'b000:  funct_result = (dec.opcode == OP_RTYPE && dec.funct7_5) ?
			                        op_a - op_b : op_a + op_b;
			3'b001:  funct_result = op_a << op_b[4:0];
			3'b010:  funct_result = {31'd0, $signed(op_a) < $signed(op_b)};
			3'b011:  funct_result = {31'd0, op_a < op_b};
			3'b100:  funct_result = op_a ^ op_b;
			3'b101:  funct_result = dec.funct7_5 ? sra_result : op_a >> op_b[4:0];
			3'b110:  funct_result = op_a | op_b;
			default: funct_result = op_a & op_b;
		endcase

		// Branch conditions
		case (dec.funct3)
			3'b000:  cmp_true = (op_a == op_b);
			3'b001:  cmp_true = (op_a != op_b);
			3'b100:  cmp_true = $signed(op_a) < $signed(op_b);
			3'b101:  cmp_true = $signed(op_a) >= $signed(op_b);
			3'b110:  cmp_true = op_a < op_b;
			3'b111:  cmp_true = op_a >= op_b;
			default: cmp_true = 1'b0;
		endcase

		// New CSR value, B is the old one
		case (ctrl.csr_op)
			CSR_RW, CSR_RWI: csr_new = op_a;
			CSR_RS, CSR_RSI: csr_new = op_a | op_b;
			CSR_RC, CSR_RCI: csr_new = op_b & ~op_a;
			default:         csr_new = op_b;
		endcase

		case (ctrl.alu_op)
			ALU_ADD:   result = op_a + op_b;
			ALU_FUNCT: result = funct_result;
			ALU_CSR:   result = csr_new;
			default:   result = 32'd0;
		endcase
	end

	// Only meaningful on branches
	assign branch_taken = (ctrl.alu_op == ALU_CMP) && cmp_true;

endmodule

/* logic/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
	parameter logic [31:0] hart_id = 32'd0
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [11:0]          csr_addr,
	input  rv_core_pkg::csr_op_e csr_op,
	input  logic [31:0]          wdata,
	input  logic                 we,
	output logic [31:0]          rdata
);
	import rv_core_pkg::*;

	// Machine-mode CSR addresses
	localparam logic [11:0] addr_mscratch = 12'h340;
	localparam logic [11:0] addr_mcycle   = 12'hb00;
	localparam logic [11:0] addr_mhartid  = 12'hf14;

	logic [31:0] mscratch;
	logic [31:0] mcycle;
	logic        write_en;

	// No write without a real CSR operation
	assign write_en = we && (csr_op != CSR_NONE);

	// Old value, read before the update
	always_comb begin
		case (csr_addr)
			addr_mscratch: rdata = mscratch;
			addr_mcycle:   rdata = mcycle;
			addr_mhartid:  rdata = hart_id;
			default:       rdata = 32'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mscratch <= 32'd0;
			mcycle   <= 32'd0;
		end else begin
			// Free-running cycle count
			mcycle <= mcycle + 32'd1;
			if (write_en) begin
				case (csr_addr)
					addr_mscratch: mscratch <= wdata;
					// Software write wins over the increment
					addr_mcycle:   mcycle <= wdata;
					default: begin
						// mhartid is read-only
					end
				endcase
			end
		end
	end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
	parameter logic [31:0] reset_pc = 32'h0000_0000,
	parameter logic [31:0] hart_id  = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_read,
	output logic        dmem_write,
	input  logic [31:0] dmem_rdata
);
	import rv_core_pkg::*;

	// addi x0, x0, 0
	localparam logic [31:0] nop_instr = 32'h0000_0013;

	phase_e      phase;
	logic        write_done;
	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] pc_next;
	logic [31:0] instr_q;
	logic [31:0] instr;
	decoded_t    dec;
	ctrl_t       ctrl;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] rf_wdata;
	logic [31:0] alu_result;
	logic        branch_taken;
	logic [31:0] csr_rdata;
	logic        csr_we;

	// Fetch then execute, alternating every clock
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_FETCH;
		end else begin
			phase <= (phase == PH_FETCH) ? PH_EXECUTE : PH_FETCH;
		end
	end

	assign write_done = (phase == PH_EXECUTE);

	// PC moves only at the end of execute
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (write_done) begin
			pc <= pc_next;
		end
	end

	// Last executed word, keeps decode stable during fetch
	always_ff @(posedge clk) begin
		if (reset) begin
			instr_q <= nop_instr;
		end else if (write_done) begin
			instr_q <= imem_rdata;
		end
	end

	// ROM data arrives in the execute cycle
	assign instr     = write_done ? imem_rdata : instr_q;
	assign imem_addr = pc;

	instr_decoder u_decoder (
		.instr (instr),
		.dec   (dec)
	);

	control_unit u_control (
		.write_done (write_done),
		.opcode     (dec.opcode),
		.funct3     (dec.funct3),
		.ctrl       (ctrl)
	);

	register_file u_regs (
		.clk   (clk),
		.reset (reset),
		.rs1   (dec.rs1),
		.rs2   (dec.rs2),
		.rd    (dec.rd),
		.wdata (rf_wdata),
		.we    (ctrl.rf_write),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu u_alu (
		.ctrl         (ctrl),
		.dec          (dec),
		.pc           (pc),
		.rd1          (rd1),
		.rd2          (rd2),
		.csr_rdata    (csr_rdata),
		.result       (alu_result),
		.branch_taken (branch_taken)
	);

	// CSR write whenever a Zicsr op executes
	assign csr_we = (ctrl.alu_op == ALU_CSR);

	csr_file #(
		.hart_id (hart_id)
	) u_csr (
		.clk      (clk),
		.reset    (reset),
		.csr_addr (dec.csr_addr),
		.csr_op   (ctrl.csr_op),
		.wdata    (alu_result),
		.we       (csr_we),
		.rdata    (csr_rdata)
	);

	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		// Jump target with bit 0 cleared, as JALR requires
		if (ctrl.jump) begin
			pc_next = {alu_result[31:1], 1'b0};
		end else if (ctrl.branch && branch_taken) begin
			pc_next = pc + dec.imm;
		end else begin
			pc_next = pc_plus4;
		end

		// Write-back source
		case (ctrl.rf_wd_select)
			RF_WD_LUI:  rf_wdata = dec.imm;
			RF_WD_ALU:  rf_wdata = alu_result;
			RF_WD_JUMP: rf_wdata = pc_plus4;
			RF_WD_LOAD: rf_wdata = dmem_rdata;
			RF_WD_CSR:  rf_wdata = csr_rdata;
			default:    rf_wdata = 32'd0;
		endcase
	end

	// Word access at R[rs1] + imm
	assign dmem_addr  = alu_result;
	assign dmem_wdata = rd2;
	assign dmem_read  = ctrl.mem_read;
	assign dmem_write = ctrl.mem_write;

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
	parameter int period       = 40,
	parameter int reset_cycles = 16
) (
	output logic clk,
	output logic reset
);

	// Free-running clock, low at time zero
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Reset released on a falling edge, like all other inputs
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

	localparam logic [31:0] reset_pc = 32'h0000_0100;
	localparam logic [31:0] hart_id  = 32'h0000_0003;
	// RV32I major opcodes for the program builder
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_fence  = 7'b0001111;
	localparam logic [6:0] op_system = 7'b1110011;
	localparam logic [31:0] nop = 32'h0000_0013;
	// Any store to this address marks a wrong path
	localparam logic [11:0] poison_addr = 12'h3fc;

	logic        clk;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_read;
	logic        dmem_write;
	logic [31:0] dmem_rdata;

	logic [31:0] rom [0:127];
	logic [31:0] ram [0:255];
	logic [31:0] exp_addr [0:63];
	logic [31:0] exp_value [0:63];
	logic [31:0] exp_actual [0:63];
	logic        exp_any [0:63];
	logic        exp_seen [0:63];
	string       exp_name [0:63];
	int          exp_count;
	int          prog_len;
	logic [31:0] halt_pc;
	logic [31:0] rom_offset;
	int          store_idx;
	logic [5:0]  store_slot;
	logic        store_known;
	logic        store_free;
	logic [31:0] store_expect;
	integer      seed;
	logic [31:0] a_val;
	logic [31:0] b_val;
	logic [31:0] c_val;
	int          error_count;
	int          cycle_count;
	int          cycle_limit;
	int          cycle_first;
	int          cycle_second;

	clock_gen #(.period(40), .reset_cycles(16)) u_clock (.clk(clk), .reset(reset));

	rv_core #(
		.reset_pc (reset_pc),
		.hart_id  (hart_id)
	) u_dut (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_read  (dmem_read),
		.dmem_write (dmem_write),
		.dmem_rdata (dmem_rdata)
	);

	// Instruction formats per the RV32I spec
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_word(input logic [4:0] rs2, input logic [11:0] imm);
		// Word store based on x0
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// Address of the next instruction to be emitted
	function automatic logic [31:0] here();
		return reset_pc + 32'(prog_len * 4);
	endfunction

	function automatic int find_store(input logic [31:0] addr);
		int idx;
		idx = -1;
		for (int i = 0; i < exp_count; i++) begin
			if (exp_addr[6'(i)] == addr) idx = i;
		end
		return idx;
	endfunction

	task automatic emit(input logic [31:0] word);
		rom[7'(prog_len)] = word;
		prog_len++;
	endtask

	// Store rs to the next result slot along with its expected value
	task automatic store_check(input string name, input logic [4:0] rs,
			input logic [31:0] value, input logic any);
		logic [31:0] addr;
		addr = 32'h0000_0100 + 32'(exp_count * 4);
		exp_addr[6'(exp_count)]  = addr;
		exp_value[6'(exp_count)] = value;
		exp_any[6'(exp_count)]   = any;
		exp_seen[6'(exp_count)]  = 1'b0;
		exp_name[6'(exp_count)]  = name;
		exp_count++;
		emit(s_word(rs, addr[11:0]));
	endtask

	task automatic poison_store();
		emit(s_word(5'd30, poison_addr));
	endtask

	// Computes x3 = x1 op x2 and stores it
	task automatic r_check(input string name, input logic [6:0] f7, input logic [2:0] f3,
			input logic [31:0] value);
		emit(r_word(f7, 5'd2, 5'd1, f3, 5'd3));
		store_check(name, 5'd3, value, 1'b0);
	endtask

	// Computes x3 = x1 op imm and stores it
	task automatic i_check(input string name, input logic [2:0] f3, input logic [11:0] imm,
			input logic [31:0] value);
		emit(i_word(op_imm, f3, 5'd3, 5'd1, imm));
		store_check(name, 5'd3, value, 1'b0);
	endtask

	// Taken branch skips the poison store
	// Not taken falls through to the store of x10
	task automatic branch_check(input string name, input logic [2:0] f3,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic taken);
		emit(b_word(f3, rs1, rs2, 13'd8));
		if (taken) poison_store();
		else store_check(name, 5'd10, 32'd5, 1'b0);
	endtask

	task automatic build_program();
		logic [11:0] imm;
		logic [31:0] ext;
		logic [4:0]  sh;
		logic [4:0]  shamt;
		logic [31:0] pc;
		imm   = 12'($random(seed));
		shamt = 5'($random(seed));
		ext   = {{20{imm[11]}}, imm};
		sh    = b_val[4:0];
		// Operands, constants and the poison marker
		emit(i_word(op_load, 3'b010, 5'd1, 5'd0, 12'h000));
		emit(i_word(op_load, 3'b010, 5'd2, 5'd0, 12'h004));
		emit(i_word(op_load, 3'b010, 5'd8, 5'd0, 12'h008));
		emit({20'hdead0, 5'd30, op_lui});
		emit(i_word(op_imm, 3'b000, 5'd10, 5'd0, 12'd5));
		emit(i_word(op_imm, 3'b000, 5'd11, 5'd0, 12'hffd));
		emit(i_word(op_imm, 3'b000, 5'd12, 5'd0, 12'd5));
		r_check("add", 7'h00, 3'b000, a_val + b_val);
		r_check("sub", 7'h20, 3'b000, a_val - b_val);
		r_check("sll", 7'h00, 3'b001, a_val << sh);
		r_check("slt", 7'h00, 3'b010, {31'd0, $signed(a_val) < $signed(b_val)});
		r_check("sltu", 7'h00, 3'b011, {31'd0, a_val < b_val});
		r_check("xor", 7'h00, 3'b100, a_val ^ b_val);
		r_check("srl", 7'h00, 3'b101, a_val >> sh);
		r_check("sra", 7'h20, 3'b101, $signed(a_val) >>> sh);
		r_check("or", 7'h00, 3'b110, a_val | b_val);
		r_check("and", 7'h00, 3'b111, a_val & b_val);
		i_check("addi", 3'b000, imm, a_val + ext);
		i_check("slti", 3'b010, imm, {31'd0, $signed(a_val) < $signed(ext)});
		i_check("sltiu", 3'b011, imm, {31'd0, a_val < ext});
		i_check("xori", 3'b100, imm, a_val ^ ext);
		i_check("ori", 3'b110, imm, a_val | ext);
		i_check("andi", 3'b111, imm, a_val & ext);
		i_check("slli", 3'b001, {7'h00, shamt}, a_val << shamt);
		i_check("srli", 3'b101, {7'h00, shamt}, a_val >> shamt);
		i_check("srai", 3'b101, {7'h20, shamt}, $signed(a_val) >>> shamt);
		emit({20'habcde, 5'd3, op_lui});
		store_check("lui", 5'd3, 32'habcde000, 1'b0);
		pc = here();
		emit({20'h12345, 5'd3, op_auipc});
		store_check("auipc", 5'd3, pc + 32'h12345000, 1'b0);
		// x10 = 5, x11 = -3, x12 = 5
		branch_check("beq", 3'b000, 5'd10, 5'd12, 1'b1);
		branch_check("beq_not", 3'b000, 5'd10, 5'd11, 1'b0);
		branch_check("bne", 3'b001, 5'd10, 5'd11, 1'b1);
		branch_check("bne_not", 3'b001, 5'd10, 5'd12, 1'b0);
		branch_check("blt", 3'b100, 5'd11, 5'd10, 1'b1);
		branch_check("blt_not", 3'b100, 5'd10, 5'd11, 1'b0);
		branch_check("bge", 3'b101, 5'd10, 5'd11, 1'b1);
		branch_check("bge_not", 3'b101, 5'd11, 5'd10, 1'b0);
		branch_check("bltu", 3'b110, 5'd10, 5'd11, 1'b1);
		branch_check("bltu_not", 3'b110, 5'd11, 5'd10, 1'b0);
		branch_check("bgeu", 3'b111, 5'd11, 5'd10, 1'b1);
		branch_check("bgeu_not", 3'b111, 5'd10, 5'd11, 1'b0);
		pc = here();
		emit(j_word(5'd5, 21'd8));
		poison_store();
		store_check("jal_link", 5'd5, pc + 32'd4, 1'b0);
		// JALR aims one byte past the target so bit 0 must be cleared
		pc = here();
		emit(i_word(op_imm, 3'b000, 5'd6, 5'd0, 12'(pc + 32'd12)));
		emit(i_word(op_jalr, 3'b000, 5'd7, 5'd6, 12'd1));
		poison_store();
		store_check("jalr_link", 5'd7, pc + 32'd8, 1'b0);
		// Round trip through a result slot
		store_check("store_word", 5'd8, c_val, 1'b0);
		emit(i_word(op_load, 3'b010, 5'd9, 5'd0, exp_addr[6'(exp_count - 1)][11:0]));
		store_check("load_back", 5'd9, c_val, 1'b0);
		emit(i_word(op_system, 3'b001, 5'd15, 5'd8, 12'h340));
		store_check("csrrw_old", 5'd15, 32'd0, 1'b0);
		emit(i_word(op_system, 3'b001, 5'd16, 5'd1, 12'h340));
		store_check("csrrw_new", 5'd16, c_val, 1'b0);
		emit(i_word(op_system, 3'b110, 5'd17, 5'h15, 12'h340));
		store_check("csrrsi_old", 5'd17, a_val, 1'b0);
		emit(i_word(op_system, 3'b111, 5'd18, 5'h0a, 12'h340));
		store_check("csrrci_old", 5'd18, a_val | 32'h15, 1'b0);
		emit(i_word(op_system, 3'b010, 5'd19, 5'd0, 12'h340));
		store_check("csr_bits", 5'd19, (a_val | 32'h15) & ~32'h0a, 1'b0);
		emit(i_word(op_system, 3'b010, 5'd20, 5'd0, 12'hf14));
		store_check("mhartid", 5'd20, hart_id, 1'b0);
		emit(i_word(op_system, 3'b010, 5'd21, 5'd0, 12'hb00));
		emit(i_word(op_system, 3'b010, 5'd22, 5'd0, 12'hb00));
		cycle_first = exp_count;
		store_check("mcycle_first", 5'd21, 32'd0, 1'b1);
		cycle_second = exp_count;
		store_check("mcycle_second", 5'd22, 32'd0, 1'b1);
		// FENCE must leave registers and CSRs alone
		// Its reserved rd field names x16, which must keep its value
		emit(i_word(op_fence, 3'b000, 5'd16, 5'd0, 12'h0ff));
		emit(i_word(op_system, 3'b010, 5'd23, 5'd0, 12'h340));
		store_check("fence_csr", 5'd23, (a_val | 32'h15) & ~32'h0a, 1'b0);
		store_check("fence_reg", 5'd16, c_val, 1'b0);
		halt_pc = here();
		emit(j_word(5'd0, 21'd0));
	endtask

	assign store_idx    = find_store(dmem_addr);
	assign store_slot   = 6'(store_idx);
	assign store_known  = (store_idx >= 0);
	assign store_free   = exp_any[store_slot];
	assign store_expect = exp_value[store_slot];
	assign rom_offset   = imem_addr - reset_pc;

	// ROM and RAM read data change on the falling edge
	// RAM hands out its contents only while the core strobes a read
	always @(negedge clk) begin
		if (rom_offset < 32'd512) imem_rdata = rom[rom_offset[8:2]];
		else imem_rdata = nop;
		if (dmem_read) dmem_rdata = ram[dmem_addr[9:2]];
		else dmem_rdata = 32'hdead_beef;
	end

	// RAM write and store bookkeeping
	always @(posedge clk) begin
		if (!reset && dmem_write) begin
			ram[dmem_addr[9:2]] = dmem_wdata;
			if (store_known) begin
				exp_seen[store_slot]   = 1'b1;
				exp_actual[store_slot] = dmem_wdata;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			cycle_count = cycle_count + 1;
			if (cycle_count > cycle_limit) begin
				$display("Timeout after %0d cycles, halt loop never fetched", cycle_count);
				$display("SOME TESTS FAILED");
				$finish;
			end
		end
	end

	reset_idle: assert property (@(posedge clk) ((reset && $past(reset)) || $fell(reset)) |->
			(!dmem_read && !dmem_write && imem_addr == reset_pc))
		else begin
			error_count++;
			$display("Strobe active or imem_addr %h off reset_pc near reset", $sampled(imem_addr));
		end

	store_address: assert property (@(posedge clk) disable iff (reset) dmem_write |-> store_known)
		else begin
			error_count++;
			$display("Store to unexpected address %h, a wrong path ran", $sampled(dmem_addr));
		end

	store_value: assert property (@(posedge clk) disable iff (reset)
			(dmem_write && store_known && !store_free) |-> (dmem_wdata == store_expect))
		else begin
			error_count++;
			$display("** Error %s: expected %h, actual %h", exp_name[$sampled(store_slot)],
				$sampled(store_expect), $sampled(dmem_wdata));
		end

	initial begin
		seed        = 32'h4dca;
		error_count = 0;
		cycle_count = 0;
		prog_len    = 0;
		exp_count   = 0;
		imem_rdata  = nop;
		dmem_rdata  = 32'd0;
		// Each word starts out holding its own byte address
		for (int i = 0; i < 256; i++) ram[8'(i)] = 32'hbad0_0000 | 32'(i * 4);
		for (int i = 0; i < 128; i++) rom[7'(i)] = nop;
		a_val = $random(seed);
		b_val = $random(seed);
		c_val = $random(seed);
		ram[8'd0] = a_val;
		ram[8'd1] = b_val;
		ram[8'd2] = c_val;
		build_program();
		cycle_limit = 2 * prog_len + 64;

		@(negedge reset);
		while (imem_addr != halt_pc) @(negedge clk);
		// Let the last store retire
		repeat (4) @(negedge clk);

		for (int i = 0; i < exp_count; i++) begin
			assert (exp_seen[6'(i)])
				else begin
					error_count++;
					$display("No store seen for %s at %h", exp_name[6'(i)], exp_addr[6'(i)]);
				end
		end
		assert (exp_actual[6'(cycle_second)] > exp_actual[6'(cycle_first)])
			else begin
				error_count++;
				$display("** Error mcycle_order: expected above %h, actual %h",
					exp_actual[6'(cycle_first)], exp_actual[6'(cycle_second)]);
			end

		$display("Run finished with %0d errors", error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* rv_core.f */
logic/rv_core_pkg.sv
logic/instr_decoder.sv
logic/control_unit.sv
logic/register_file.sv
logic/alu.sv
logic/csr_file.sv
logic/rv_core.sv
test/clock_gen.sv
test/rv_core_tb.sv

/* Makefile */
TOP := rv_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
